// File: src/flight_pkg.sv
// Shared rate-control constants; gains and shifts are fixed at elaboration and all rates are signed 16-bit.
`default_nettype none

package flight_pkg;

	localparam int RATE_W = 16; // width of rates, angles and angle errors.
	localparam int GAIN_W = 16; // width of the signed pid gains.
	localparam int SHIFT_W = 4; // width of the term scaling shifts.

	localparam int ERR_W = RATE_W + 1; // rotation error keeps the carry of the subtraction.
	localparam int DERR_W = RATE_W + 2; // error change is a difference of two rotation errors.
	localparam int P_W = GAIN_W + ERR_W; // full proportional product width.
	localparam int I_W = GAIN_W + RATE_W; // full integral product width.
	localparam int D_W = GAIN_W + DERR_W; // full derivative product width.
	localparam int SUM_W = D_W + 2; // room for the sum of all three terms.

	localparam logic signed [RATE_W-1:0] RATE_MIN = 16'sh8000; // lower clamp, -32768.
	localparam logic signed [RATE_W-1:0] RATE_MAX = 16'sh7fff; // upper clamp, 32767.

	localparam int ANGLE_SHIFT = 2; // angle error to target rate scaling.

	// Gains for roll and pitch; yaw overrides the proportional and derivative gains.
	localparam logic signed [GAIN_W-1:0] K_P_DEF = 16'sd5;
	localparam logic signed [GAIN_W-1:0] K_I_DEF = 16'sd3;
	localparam logic signed [GAIN_W-1:0] K_D_DEF = 16'sd2;

	localparam logic [SHIFT_W-1:0] KP_SHIFT_DEF = 4'd2;
	localparam logic [SHIFT_W-1:0] KI_SHIFT_DEF = 4'd4;
	localparam logic [SHIFT_W-1:0] KD_SHIFT_DEF = 4'd3;

	localparam logic signed [GAIN_W-1:0] K_P_YAW = 16'sd3; // yaw responds more gently.
	localparam logic signed [GAIN_W-1:0] K_D_YAW = 16'sd1;

	// one signed value per axis, roll in the upper bits.
	typedef struct packed {
		logic signed [RATE_W-1:0] roll;
		logic signed [RATE_W-1:0] pitch;
		logic signed [RATE_W-1:0] yaw;
	} axis_vec_t;

endpackage

`default_nettype wire

// File: src/angle_to_rate.sv
// Inputs must be valid in the sample cycle; a sample seen while busy is high is dropped, there is no queue.
`timescale 1ns/1ps
`default_nettype none

module angle_to_rate import flight_pkg::*; (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic sample,
	input wire logic busy,
	input wire axis_vec_t target_angle,
	input wire axis_vec_t actual_angle,
	input wire axis_vec_t actual_rate,
	output axis_vec_t target_rate,
	output axis_vec_t rate_meas,
	output axis_vec_t angle_error,
	output logic start
);

	axis_vec_t err_c; // saturated angle error of the current inputs.
	axis_vec_t rate_c; // target rate derived from err_c.
	logic accept; // a sample is taken only when the pids are idle.

	// Difference of two angles, saturated back into the rate range.
	function automatic logic signed [RATE_W-1:0] sat_diff(
		input logic signed [RATE_W-1:0] a,
		input logic signed [RATE_W-1:0] b
	);
		logic signed [RATE_W:0] diff;
		diff = a - b; // one extra bit holds the full difference.
		if (diff > RATE_MAX)
			return RATE_MAX;
		else if (diff < RATE_MIN)
			return RATE_MIN;
		else
			return diff[RATE_W-1:0];
	endfunction

	assign accept = sample & ~busy;

	always_comb begin
		err_c.roll = sat_diff(target_angle.roll, actual_angle.roll);
		err_c.pitch = sat_diff(target_angle.pitch, actual_angle.pitch);
		err_c.yaw = sat_diff(target_angle.yaw, actual_angle.yaw);
		rate_c.roll = err_c.roll >>> ANGLE_SHIFT; // arithmetic, keeps the sign.
		rate_c.pitch = err_c.pitch >>> ANGLE_SHIFT;
		rate_c.yaw = err_c.yaw >>> ANGLE_SHIFT;
	end

	// start fires the cycle after the sample is taken.
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start <= 1'b0;
		else
			start <= accept;
	end

	// these stay put until the next accepted sample, while the pids read them.
	always_ff @(posedge us_clk) begin
		if (accept) begin
			angle_error <= err_c;
			target_rate <= rate_c;
			rate_meas <= actual_rate; // measured rate travels with its sample.
		end
	end

	// busy from the top must already cover the start cycle.
	assert property (@(posedge us_clk) disable iff (!resetn) start |=> !start)
		else $error("angle_to_rate: start high in two consecutive cycles.");

endmodule

`default_nettype wire

// File: src/rate_pid.sv
// Inputs must hold from start_flag until rate_out is registered; gains and shifts are fixed at elaboration.
`timescale 1ns/1ps
`default_nettype none

module rate_pid import flight_pkg::*; #(
	parameter logic signed [GAIN_W-1:0] K_P = K_P_DEF,
	parameter logic signed [GAIN_W-1:0] K_I = K_I_DEF,
	parameter logic signed [GAIN_W-1:0] K_D = K_D_DEF,
	parameter logic [SHIFT_W-1:0] KP_SHIFT = KP_SHIFT_DEF,
	parameter logic [SHIFT_W-1:0] KI_SHIFT = KI_SHIFT_DEF,
	parameter logic [SHIFT_W-1:0] KD_SHIFT = KD_SHIFT_DEF
) (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic signed [RATE_W-1:0] target_rotation,
	input wire logic signed [RATE_W-1:0] actual_rotation,
	input wire logic signed [RATE_W-1:0] angle_error,
	input wire logic start_flag,
	input wire logic wait_flag,
	output logic signed [RATE_W-1:0] rate_out,
	output logic pid_complete,
	output logic pid_active
);

	typedef enum logic [5:0] {
		S_WAIT = 6'b000001,
		S_CALC1 = 6'b000010,
		S_CALC2 = 6'b000100,
		S_CALC3 = 6'b001000,
		S_CALC4 = 6'b010000,
		S_COMPLETE = 6'b100000
	} pid_state_t;

	pid_state_t state;
	pid_state_t next_state;

	logic signed [ERR_W-1:0] rotation_error; // carried across updates for the derivative.
	logic signed [ERR_W-1:0] prev_rotation_error;
	logic signed [DERR_W-1:0] error_change;
	logic signed [P_W-1:0] p_term;
	logic signed [I_W-1:0] i_term;
	logic signed [D_W-1:0] d_term;
	logic signed [SUM_W-1:0] rotation_total;
	logic signed [RATE_W-1:0] total_sat; // rotation_total clamped to the rate range.

	always_comb begin
		if (rotation_total < RATE_MIN)
			total_sat = RATE_MIN;
		else if (rotation_total > RATE_MAX)
			total_sat = RATE_MAX;
		else
			total_sat = rotation_total[RATE_W-1:0];
	end

	always_comb begin
		case (state)
			S_WAIT: next_state = start_flag ? S_CALC1 : S_WAIT;
			S_CALC1: next_state = S_CALC2;
			S_CALC2: next_state = S_CALC3;
			S_CALC3: next_state = S_CALC4;
			S_CALC4: next_state = S_COMPLETE;
			S_COMPLETE: next_state = wait_flag ? S_WAIT : S_COMPLETE; // all axes done together.
			default: next_state = S_WAIT;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_WAIT;
			pid_active <= 1'b0;
			pid_complete <= 1'b0;
			rate_out <= '0;
			rotation_error <= '0;
			prev_rotation_error <= '0;
		end else begin
			state <= next_state;
			case (state)
				S_WAIT: begin
					pid_active <= 1'b0;
					pid_complete <= 1'b1;
				end
				S_CALC1: begin
					pid_active <= 1'b1;
					pid_complete <= 1'b0;
					prev_rotation_error <= rotation_error; // error of the last update.
					rotation_error <= target_rotation - actual_rotation;
				end
				S_CALC2, S_CALC3, S_CALC4: begin
					pid_active <= 1'b1;
					pid_complete <= 1'b0;
				end
				S_COMPLETE: begin
					pid_complete <= 1'b1;
					if (wait_flag) begin
						pid_active <= 1'b0; // drop now so the update pulse is one cycle.
					end else begin
						pid_active <= 1'b1;
						rate_out <= total_sat;
					end
				end
				default: begin
					pid_active <= 1'b0;
					pid_complete <= 1'b0;
				end
			endcase
		end
	end

	// Multiplies are spread one per state so each cycle has one product.
	always_ff @(posedge us_clk) begin
		case (state)
			S_CALC1: i_term <= (K_I * angle_error) >>> KI_SHIFT;
			S_CALC2: begin
				p_term <= (K_P * rotation_error) >>> KP_SHIFT;
				error_change <= rotation_error - prev_rotation_error;
			end
			S_CALC3: d_term <= (K_D * error_change) >>> KD_SHIFT;
			S_CALC4: rotation_total <= p_term + i_term + d_term; // full width, clamped later.
			default: ;
		endcase
	end

	assert property (@(posedge us_clk) disable iff (!resetn) $onehot(state))
		else $error("rate_pid: state is not one-hot.");

	// the upstream busy logic must never start a pid mid-calculation.
	assert property (@(posedge us_clk) disable iff (!resetn) start_flag |-> state == S_WAIT)
		else $error("rate_pid: start_flag seen outside WAIT.");

endmodule

`default_nettype wire

// File: src/rate_controller_top.sv
// rate_cmd updates six edges after an accepted sample; samples during an update are ignored.
`timescale 1ns/1ps
`default_nettype none

module rate_controller_top import flight_pkg::*; (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic sample,
	input wire axis_vec_t target_angle,
	input wire axis_vec_t actual_angle,
	input wire axis_vec_t actual_rate,
	output axis_vec_t rate_cmd,
	output logic rate_update
);

	axis_vec_t target_rate;
	axis_vec_t rate_meas;
	axis_vec_t angle_error;
	logic start;
	logic busy;
	logic start_pending; // covers the gap between start and the pids going active.
	logic wait_flag;
	logic [2:0] pid_complete; // index 0 roll, 1 pitch, 2 yaw.
	logic [2:0] pid_active;
	logic signed [RATE_W-1:0] rate_roll;
	logic signed [RATE_W-1:0] rate_pitch;
	logic signed [RATE_W-1:0] rate_yaw;

	angle_to_rate u_angle_to_rate (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample(sample),
		.busy(busy),
		.target_angle(target_angle),
		.actual_angle(actual_angle),
		.actual_rate(actual_rate),
		.target_rate(target_rate),
		.rate_meas(rate_meas),
		.angle_error(angle_error),
		.start(start)
	);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start_pending <= 1'b0;
		else if (start)
			start_pending <= 1'b1;
		else if (|pid_active)
			start_pending <= 1'b0; // the pids have taken over.
	end

	assign busy = start | start_pending | (|pid_active);

	// every axis finishes on the same edge, so this is high for one cycle.
	assign wait_flag = &(pid_complete & pid_active);
	assign rate_update = wait_flag;

	rate_pid pid_roll (
		.us_clk(us_clk),
		.resetn(resetn),
		.target_rotation(target_rate.roll),
		.actual_rotation(rate_meas.roll),
		.angle_error(angle_error.roll),
		.start_flag(start),
		.wait_flag(wait_flag),
		.rate_out(rate_roll),
		.pid_complete(pid_complete[0]),
		.pid_active(pid_active[0])
	);

	rate_pid pid_pitch (
		.us_clk(us_clk),
		.resetn(resetn),
		.target_rotation(target_rate.pitch),
		.actual_rotation(rate_meas.pitch),
		.angle_error(angle_error.pitch),
		.start_flag(start),
		.wait_flag(wait_flag),
		.rate_out(rate_pitch),
		.pid_complete(pid_complete[1]),
		.pid_active(pid_active[1])
	);

	// Yaw has its own proportional and derivative gains.
	rate_pid #(
		.K_P(K_P_YAW),
		.K_D(K_D_YAW)
	) pid_yaw (
		.us_clk(us_clk),
		.resetn(resetn),
		.target_rotation(target_rate.yaw),
		.actual_rotation(rate_meas.yaw),
		.angle_error(angle_error.yaw),
		.start_flag(start),
		.wait_flag(wait_flag),
		.rate_out(rate_yaw),
		.pid_complete(pid_complete[2]),
		.pid_active(pid_active[2])
	);

	assign rate_cmd = '{roll: rate_roll, pitch: rate_pitch, yaw: rate_yaw}; // held between updates.

endmodule

`default_nettype wire

// File: dv/rate_controller_tb.sv
// The model gains must match the package defaults and the run stops after NUM_UPDATES samples.
`timescale 1ns/1ps
`default_nettype none

module rate_controller_tb import flight_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_UPDATES = 200;
	localparam int UPDATE_BUDGET = 20; // generous cycle budget per update including gap and busy.
	localparam int WATCHDOG_NS = NUM_UPDATES * UPDATE_BUDGET * CLK_PERIOD
		+ RESET_CYCLES * CLK_PERIOD;
	localparam int LATENCY = 7; // negedges from the sampling cycle to the update cycle.

	// model gains and shifts of the PID terms.
	localparam longint M_KP = 5;
	localparam longint M_KI = 3;
	localparam longint M_KD = 2;
	localparam longint M_KP_YAW = 3;
	localparam longint M_KD_YAW = 1;
	localparam longint M_KP_SH = 2;
	localparam longint M_KI_SH = 4;
	localparam longint M_KD_SH = 3;
	localparam longint M_ANGLE_SH = 2;

	logic us_clk;
	logic resetn;
	logic sample;
	axis_vec_t target_angle;
	axis_vec_t actual_angle;
	axis_vec_t actual_rate;
	axis_vec_t rate_cmd;
	logic rate_update;

	integer seed = 32'ha6d7_0d48;
	int gap;
	int cycle = 0;
	int due_cycle = 0;
	int accepted = 0;
	int checked = 0;
	int rejected = 0;
	int value_errors = 0;
	int other_errors = 0;
	int sat_hits = 0; // angle errors that had to saturate.
	int max_hits = 0;
	int min_hits = 0;
	bit pending = 1'b0;
	bit model_busy = 1'b0;
	bit is_due;
	axis_vec_t pending_cmd = '0;
	axis_vec_t last_cmd = '0; // rate_cmd is zero out of reset.
	longint prev_err [3] = '{0, 0, 0}; // indexed roll, pitch, yaw.

	rate_controller_top dut0 (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample(sample),
		.target_angle(target_angle),
		.actual_angle(actual_angle),
		.actual_rate(actual_rate),
		.rate_cmd(rate_cmd),
		.rate_update(rate_update)
	);

	initial begin
		us_clk = 1'b0;
		forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
	end

	function automatic longint clamp16(input longint v);
		if (v > 32767)
			return 32767;
		else if (v < -32768)
			return -32768;
		else
			return v;
	endfunction

	// Small values keep most sums inside the limits while the full range drives the clamps.
	function automatic logic signed [RATE_W-1:0] random_value(input logic big);
		integer r;
		r = $random(seed);
		if (big)
			return r[RATE_W-1:0];
		else
			return r % 1500;
	endfunction

	function automatic axis_vec_t random_vec(input logic big);
		axis_vec_t v;
		v.roll = random_value(big);
		v.pitch = random_value(big);
		v.yaw = random_value(big);
		return v;
	endfunction

	task automatic model_axis(
		input longint tgt_angle,
		input longint act_angle,
		input longint act_rate,
		input longint kp,
		input longint kd,
		input longint prev,
		output longint cmd,
		output longint rot_err
	);
		longint ang_err;
		longint sum;
		ang_err = clamp16(tgt_angle - act_angle);
		if (ang_err != tgt_angle - act_angle)
			sat_hits++;
		rot_err = (ang_err >>> M_ANGLE_SH) - act_rate;
		sum = ((kp * rot_err) >>> M_KP_SH) + ((M_KI * ang_err) >>> M_KI_SH)
			+ ((kd * (rot_err - prev)) >>> M_KD_SH);
		cmd = clamp16(sum);
		if (sum > 32767)
			max_hits++;
		if (sum < -32768)
			min_hits++;
	endtask

	task automatic accept_sample();
		longint cmd_v;
		longint rot_v;
		model_axis(target_angle.roll, actual_angle.roll, actual_rate.roll, M_KP, M_KD,
			prev_err[0], cmd_v, rot_v);
		prev_err[0] = rot_v;
		pending_cmd.roll = cmd_v[RATE_W-1:0];
		model_axis(target_angle.pitch, actual_angle.pitch, actual_rate.pitch, M_KP, M_KD,
			prev_err[1], cmd_v, rot_v);
		prev_err[1] = rot_v;
		pending_cmd.pitch = cmd_v[RATE_W-1:0];
		model_axis(target_angle.yaw, actual_angle.yaw, actual_rate.yaw, M_KP_YAW, M_KD_YAW,
			prev_err[2], cmd_v, rot_v);
		prev_err[2] = rot_v;
		pending_cmd.yaw = cmd_v[RATE_W-1:0];
		pending = 1'b1;
		due_cycle = cycle + LATENCY;
		model_busy = 1'b1;
		accepted++;
	endtask

	task automatic check_axis(
		input string axis,
		input logic signed [RATE_W-1:0] got,
		input logic signed [RATE_W-1:0] exp
	);
		assert (got == exp) else begin
			$display("Fail %0t: %s rate is %0d, expected %0d.", $time, axis, got, exp);
			value_errors++;
		end
	endtask

	task automatic drive_cycle(input logic strobe);
		logic big;
		@(posedge us_clk);
		#DRIVE_DELAY;
		big = ($random(seed) % 2) != 0;
		sample = strobe;
		target_angle = random_vec(big); // fresh values every cycle even without a strobe.
		actual_angle = random_vec(big);
		actual_rate = random_vec(big);
	endtask

	task automatic print_summary();
		$display("updates checked %0d, samples dropped %0d, value errors %0d, other errors %0d",
			checked, rejected, value_errors, other_errors);
	endtask

	// Inputs are stable at the falling edge, so the model sees what the next edge samples.
	always @(negedge us_clk) begin
		if (resetn) begin
			cycle++;
			is_due = pending && (cycle == due_cycle);
			assert (rate_update == is_due) else begin
				$display("Fail %0t: rate_update is %b, expected %b.", $time, rate_update, is_due);
				value_errors++;
			end
			if (is_due) begin
				check_axis("roll", rate_cmd.roll, pending_cmd.roll);
				check_axis("pitch", rate_cmd.pitch, pending_cmd.pitch);
				check_axis("yaw", rate_cmd.yaw, pending_cmd.yaw);
				last_cmd = pending_cmd;
				pending = 1'b0;
				checked++;
			end else begin
				assert (rate_cmd == last_cmd) else begin
					$display("Fail %0t: rate_cmd changed between updates.", $time);
					value_errors++;
				end
			end
			if (sample && !model_busy)
				accept_sample();
			else if (sample)
				rejected++; // the update cycle itself still counts as busy.
			if (is_due)
				model_busy = 1'b0;
		end
	end

	initial begin
		resetn = 1'b0;
		sample = 1'b0;
		target_angle = '0;
		actual_angle = '0;
		actual_rate = '0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		#DRIVE_DELAY resetn = 1'b1;
		repeat (5) @(posedge us_clk); // idle cycles show the reset state.
		while (accepted < NUM_UPDATES) begin
			drive_cycle(1'b1);
			gap = $unsigned($random(seed)) % 13;
			repeat (gap) drive_cycle(1'b0);
		end
		drive_cycle(1'b0);
		while (checked != accepted)
			@(posedge us_clk);
		repeat (2) @(posedge us_clk);
		assert (max_hits > 0 && min_hits > 0) else begin
			$display("The random samples never drove a sum past both clamp limits.");
			other_errors++;
		end
		assert (sat_hits > 0) else begin
			$display("No angle error ever needed to saturate.");
			other_errors++;
		end
		assert (rejected > 0) else begin
			$display("No sample arrived while the controller was busy.");
			other_errors++;
		end
		print_summary();
		if (value_errors + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout after %0d ns, the run hung before all updates were checked.",
			WATCHDOG_NS);
		other_errors++;
		print_summary();
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/flight_pkg.sv
src/angle_to_rate.sv
src/rate_pid.sv
src/rate_controller_top.sv
dv/rate_controller_tb.sv

// File: Bender.yml
package:
  name: rate_controller

sources:
  - src/flight_pkg.sv
  - src/angle_to_rate.sv
  - src/rate_pid.sv
  - src/rate_controller_top.sv
  - target: test
    files:
      - dv/rate_controller_tb.sv
